//--- verilog/fpu_pkg.sv
package fpu_pkg;

    // Float format: sign, biased exponent, fraction with hidden one
    localparam int FP_W   = 27;
    localparam int EXP_W  = 8;
    localparam int FRAC_W = 18;
    localparam int INT_W  = 16;

    typedef logic [FP_W-1:0] fp_t;

    // Exponent of 1.0
    localparam logic [EXP_W-1:0] EXP_BIAS = 8'd127;

    // Clip value for float to integer
    localparam logic signed [INT_W-1:0] INT_MAX = 16'sd32767;

    // 1.5 and the initial-guess constant for inverse square root
    localparam fp_t FP_ONE_HALF_3  = 27'd33423360;
    localparam fp_t INV_SQRT_MAGIC = 27'd49920718;

    typedef enum logic [2:0] {
        OP_MUL       = 3'd0,
        OP_ADD       = 3'd1,
        OP_INV_SQRT  = 3'd2,
        OP_INT_TO_FP = 3'd3,
        OP_FP_TO_INT = 3'd4
    } fpu_op_e;

    // Wishbone data and word address widths
    localparam int BUS_W = 32;
    localparam int ADR_W = 3;

    // Register map
    localparam logic [ADR_W-1:0] REG_OPA    = 3'd0;
    localparam logic [ADR_W-1:0] REG_OPB    = 3'd1;
    localparam logic [ADR_W-1:0] REG_CMD    = 3'd2;
    localparam logic [ADR_W-1:0] REG_RESULT = 3'd3;
    localparam logic [ADR_W-1:0] REG_STATUS = 3'd4;

    // Cycles from launch to a valid datapath result
    localparam int LAT_W = 3;
    localparam logic [LAT_W-1:0] LAT_MUL       = 3'd1;
    localparam logic [LAT_W-1:0] LAT_ADD       = 3'd3;
    localparam logic [LAT_W-1:0] LAT_INV_SQRT  = 3'd6;
    localparam logic [LAT_W-1:0] LAT_INT_TO_FP = 3'd1;
    localparam logic [LAT_W-1:0] LAT_FP_TO_INT = 3'd1;

    function automatic logic [LAT_W-1:0] op_latency(input fpu_op_e op);
        case (op)
            OP_MUL:       return LAT_MUL;
            OP_ADD:       return LAT_ADD;
            OP_INV_SQRT:  return LAT_INV_SQRT;
            OP_INT_TO_FP: return LAT_INT_TO_FP;
            OP_FP_TO_INT: return LAT_FP_TO_INT;
            // Undefined codes just yield zero after one cycle
            default:      return 3'd1;
        endcase
    endfunction

endpackage

//--- verilog/fp_mul.sv
`timescale 1ns/1ps

module fp_mul (
    input  fpu_pkg::fp_t a,
    input  fpu_pkg::fp_t b,
    output fpu_pkg::fp_t prod
);

    // Mantissas with the hidden one restored
    logic [fpu_pkg::FRAC_W:0]       a_m;
    logic [fpu_pkg::FRAC_W:0]       b_m;
    logic [2*fpu_pkg::FRAC_W+1:0]   p;
    logic                           hi;
    logic [fpu_pkg::EXP_W+1:0]      e_sum;
    logic [fpu_pkg::EXP_W-1:0]      e_out;
    logic [fpu_pkg::FRAC_W-1:0]     f_out;
    logic                           underflow;
    logic                           any_zero;

    assign a_m = {1'b1, a[17:0]};
    assign b_m = {1'b1, b[17:0]};
    assign p   = a_m * b_m;

    // Product of two values in [1,2) lies in [1,4)
    assign hi = p[37];

    // Exponent sum with the normalisation carry, bias still doubled
    assign e_sum = {2'b0, a[25:18]} + {2'b0, b[25:18]} + {9'b0, hi};

    // Result exponent would be zero or negative
    assign underflow = e_sum <= {2'b0, fpu_pkg::EXP_BIAS};
    // No overflow detection
    assign e_out = 8'(e_sum - {2'b0, fpu_pkg::EXP_BIAS});

    // Drop the leading one, keep the next 18 bits
    assign f_out = hi ? p[36:19] : p[35:18];

    // Any zero exponent means a zero operand
    assign any_zero = (a[25:18] == '0) || (b[25:18] == '0);

    assign prod = (any_zero || underflow) ? '0 : {a[26] ^ b[26], e_out, f_out};

endmodule

//--- verilog/fp_add.sv
`timescale 1ns/1ps

module fp_add (
    input  logic         iCLK,
    input  fpu_pkg::fp_t a,
    input  fpu_pkg::fp_t b,
    output fpu_pkg::fp_t sum
);

    logic [fpu_pkg::EXP_W-1:0] a_e;
    logic [fpu_pkg::EXP_W-1:0] b_e;
    logic [fpu_pkg::FRAC_W:0]  a_m;
    logic [fpu_pkg::FRAC_W:0]  b_m;
    logic                      a_big;
    logic [fpu_pkg::EXP_W-1:0] big_e;
    logic [fpu_pkg::EXP_W-1:0] exp_diff;
    logic [36:0]               big_al;
    logic [36:0]               small_al;
    logic [36:0]               raw;

    // Stage 1 registers
    logic [36:0]               raw_q;
    logic [fpu_pkg::EXP_W-1:0] exp_q;
    logic                      sign_q;
    logic                      a_zero_q;
    logic                      b_zero_q;
    fpu_pkg::fp_t              a_q;
    fpu_pkg::fp_t              b_q;

    // Stage 2 normalisation
    logic [5:0]                lz;
    logic [36:0]               norm;
    logic [fpu_pkg::EXP_W:0]   exp_up;
    logic [fpu_pkg::EXP_W-1:0] res_e;
    logic                      underflow;

    assign a_e = a[25:18];
    assign b_e = b[25:18];
    assign a_m = {1'b1, a[17:0]};
    assign b_m = {1'b1, b[17:0]};

    // Larger magnitude by exponent, then by fraction
    assign a_big = (a_e > b_e) || ((a_e == b_e) && (a[17:0] > b[17:0]));
    assign big_e    = a_big ? a_e : b_e;
    assign exp_diff = a_big ? (a_e - b_e) : (b_e - a_e);

    // Hidden one sits at bit 35, bit 36 takes the carry
    assign big_al   = {1'b0, (a_big ? a_m : b_m), 17'b0};
    assign small_al = (exp_diff > 8'd35) ? '0 :
                      ({1'b0, (a_big ? b_m : a_m), 17'b0} >> exp_diff);

    // Unlike signs subtract, smaller from larger
    assign raw = (a[26] ^ b[26]) ? (big_al - small_al) : (big_al + small_al);

    always_ff @(posedge iCLK) begin
        raw_q    <= raw;
        exp_q    <= big_e;
        sign_q   <= a_big ? a[26] : b[26];
        a_zero_q <= (a_e == '0);
        b_zero_q <= (b_e == '0);
        a_q      <= a;
        b_q      <= b;
    end

    // Distance of the leading one below bit 36
    always_comb begin
        lz = 6'd37;
        for (int i = 0; i < 37; i++) begin
            if (raw_q[i]) begin
                lz = 6'(36 - i);
            end
        end
    end

    assign norm = raw_q << lz;

    // Leading one at bit 35 keeps the larger exponent
    assign exp_up    = {1'b0, exp_q} + 9'd1;
    assign underflow = exp_up <= {3'b0, lz};
    assign res_e     = 8'(exp_up - {3'b0, lz});

    always_ff @(posedge iCLK) begin
        if (a_zero_q && b_zero_q) begin
            sum <= '0;
        end else if (a_zero_q) begin
            sum <= b_q;
        end else if (b_zero_q) begin
            sum <= a_q;
        end else if (underflow || (raw_q == '0)) begin
            // Exact cancellation lands here too
            sum <= '0;
        end else begin
            sum <= {sign_q, res_e, norm[35:18]};
        end
    end

endmodule

//--- verilog/fp_inv_sqrt.sv
`timescale 1ns/1ps

module fp_inv_sqrt (
    input  logic         iCLK,
    input  fpu_pkg::fp_t a,
    output fpu_pkg::fp_t inv_sqrt
);

    fpu_pkg::fp_t y_1;
    fpu_pkg::fp_t half_1;
    fpu_pkg::fp_t ysq_1;
    fpu_pkg::fp_t ysq_2;
    fpu_pkg::fp_t half_2;
    fpu_pkg::fp_t hprod_2;
    fpu_pkg::fp_t hprod_3;
    fpu_pkg::fp_t corr;
    fpu_pkg::fp_t corr_5;
    fpu_pkg::fp_t y_5;
    // Guess delay line, one entry per edge
    fpu_pkg::fp_t y_dly [4];

    // Bit-level first guess
    assign y_1 = fpu_pkg::INV_SQRT_MAGIC - (a >> 1);
    // Halving is an exponent decrement
    assign half_1 = {a[26], a[25:18] - 8'd1, a[17:0]};

    // Stage 1, y squared
    fp_mul u_sq (
        .a    (y_1),
        .b    (y_1),
        .prod (ysq_1)
    );

    // Stage 2, times a/2
    fp_mul u_half (
        .a    (half_2),
        .b    (ysq_2),
        .prod (hprod_2)
    );

    // Stages 3 and 4, 1.5 minus the product
    fp_add u_sub (
        .iCLK (iCLK),
        .a    ({~hprod_3[26], hprod_3[25:0]}),
        .b    (fpu_pkg::FP_ONE_HALF_3),
        .sum  (corr)
    );

    // Stage 5, correction times guess
    fp_mul u_newton (
        .a    (y_5),
        .b    (corr_5),
        .prod (inv_sqrt)
    );

    always_ff @(posedge iCLK) begin
        ysq_2   <= ysq_1;
        half_2  <= half_1;
        hprod_3 <= hprod_2;
        // Adder output lines up with the fifth edge
        corr_5  <= corr;
        y_dly[0] <= y_1;
        for (int i = 1; i < 4; i++) begin
            y_dly[i] <= y_dly[i-1];
        end
        y_5 <= y_dly[3];
    end

endmodule

//--- verilog/fp_int_convert.sv
`timescale 1ns/1ps

module fp_int_convert (
    input  logic signed [fpu_pkg::INT_W-1:0] int_in,
    input  fpu_pkg::fp_t                     fp_in,
    output fpu_pkg::fp_t                     fp_out,
    output logic signed [fpu_pkg::INT_W-1:0] int_out
);

    logic                      neg_in;
    logic [fpu_pkg::INT_W-1:0] mag;
    logic [3:0]                msb;
    logic [33:0]               i2f_buf;
    logic [fpu_pkg::EXP_W-1:0] f_e;
    logic [33:0]               f2i_buf;
    logic [fpu_pkg::INT_W-1:0] f2i_mag;

    // Integer to float
    assign neg_in = int_in[15];
    // Magnitude of -32768 still fits unsigned
    assign mag = neg_in ? 16'(-int_in) : int_in;

    // Position of the leading one
    always_comb begin
        msb = 4'd0;
        for (int i = 0; i < 16; i++) begin
            if (mag[i]) begin
                msb = 4'(i);
            end
        end
    end

    // Leading one moved to bit 18, below it is the fraction
    assign i2f_buf = {18'b0, mag} << (5'd18 - {1'b0, msb});

    assign fp_out = (int_in == '0) ? '0 :
                    {neg_in, fpu_pkg::EXP_BIAS + {4'b0, msb}, i2f_buf[17:0]};

    // Float to integer
    assign f_e = fp_in[25:18];
    // 1.f shifted up by the unbiased exponent, integer part in [33:18]
    assign f2i_buf = {15'b0, 1'b1, fp_in[17:0]} << (f_e - fpu_pkg::EXP_BIAS);
    assign f2i_mag = f2i_buf[33:18];

    always_comb begin
        if (f_e < fpu_pkg::EXP_BIAS) begin
            // Magnitude below one
            int_out = '0;
        end else if (f_e > fpu_pkg::EXP_BIAS + 8'd14) begin
            int_out = fp_in[26] ? -fpu_pkg::INT_MAX : fpu_pkg::INT_MAX;
        end else if (fp_in[26]) begin
            int_out = -$signed(f2i_mag);
        end else begin
            int_out = $signed(f2i_mag);
        end
    end

endmodule

//--- verilog/fpu_datapath.sv
`timescale 1ns/1ps

module fpu_datapath (
    input  logic             iCLK,
    input  logic             rst,
    input  fpu_pkg::fpu_op_e opcode,
    input  fpu_pkg::fp_t     op_a,
    input  fpu_pkg::fp_t     op_b,
    output fpu_pkg::fp_t     result
);

    fpu_pkg::fp_t                     prod;
    fpu_pkg::fp_t                     sum;
    fpu_pkg::fp_t                     inv;
    fpu_pkg::fp_t                     i2f;
    logic signed [fpu_pkg::INT_W-1:0] f2i;
    fpu_pkg::fp_t                     sel;

    // All units see the same operands
    fp_mul u_mul (
        .a    (op_a),
        .b    (op_b),
        .prod (prod)
    );

    fp_add u_add (
        .iCLK (iCLK),
        .a    (op_a),
        .b    (op_b),
        .sum  (sum)
    );

    fp_inv_sqrt u_inv_sqrt (
        .iCLK     (iCLK),
        .a        (op_a),
        .inv_sqrt (inv)
    );

    // Integer operand rides in the low bits of A
    fp_int_convert u_convert (
        .int_in  ($signed(op_a[fpu_pkg::INT_W-1:0])),
        .fp_in   (op_a),
        .fp_out  (i2f),
        .int_out (f2i)
    );

    always_comb begin
        case (opcode)
            fpu_pkg::OP_MUL:       sel = prod;
            fpu_pkg::OP_ADD:       sel = sum;
            fpu_pkg::OP_INV_SQRT:  sel = inv;
            fpu_pkg::OP_INT_TO_FP: sel = i2f;
            // Sign-extended integer
            fpu_pkg::OP_FP_TO_INT: sel = {{(fpu_pkg::FP_W - fpu_pkg::INT_W){f2i[15]}}, f2i};
            default:               sel = '0;
        endcase
    end

    always_ff @(posedge iCLK) begin
        if (rst) begin
            result <= '0;
        end else begin
            result <= sel;
        end
    end

endmodule

//--- verilog/fpu_wb_slave.sv
`timescale 1ns/1ps

module fpu_wb_slave (
    input  logic                      iCLK,
    input  logic                      rst,
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    input  logic [fpu_pkg::ADR_W-1:0] wb_adr,
    input  logic [fpu_pkg::BUS_W-1:0] wb_dat_i,
    output logic [fpu_pkg::BUS_W-1:0] wb_dat_o,
    output logic                      wb_ack,
    output fpu_pkg::fp_t              op_a,
    output fpu_pkg::fp_t              op_b,
    output fpu_pkg::fpu_op_e          opcode,
    input  fpu_pkg::fp_t              result
);

    logic                      req;
    logic                      served;
    logic                      stall;
    logic                      accept;
    logic                      launch;
    logic                      busy;
    logic                      done;
    logic [fpu_pkg::LAT_W-1:0] cnt;
    fpu_pkg::fpu_op_e          cmd_op;
    fpu_pkg::fp_t              result_q;

    assign req = wb_cyc && wb_stb;

    // Result reads and command writes wait for idle
    assign stall = busy &&
                   ((!wb_we && (wb_adr == fpu_pkg::REG_RESULT)) ||
                    (wb_we && (wb_adr == fpu_pkg::REG_CMD)));

    // One ack per strobe
    assign accept = req && !served && !stall;
    assign launch = accept && wb_we && (wb_adr == fpu_pkg::REG_CMD);
    assign cmd_op = fpu_pkg::fpu_op_e'(wb_dat_i[2:0]);

    // Busy while the latency count runs
    assign busy = (cnt != '0);

    always_ff @(posedge iCLK) begin
        if (rst) begin
            wb_ack   <= 1'b0;
            served   <= 1'b0;
            cnt      <= '0;
            done     <= 1'b0;
            op_a     <= '0;
            op_b     <= '0;
            opcode   <= fpu_pkg::OP_MUL;
            result_q <= '0;
        end else begin
            wb_ack <= accept;
            if (accept) begin
                served <= 1'b1;
            end else if (!req) begin
                served <= 1'b0;
            end

            // Down-counter loaded on the launch edge
            if (launch) begin
                cnt <= fpu_pkg::op_latency(cmd_op);
            end else if (busy) begin
                cnt <= cnt - 1'b1;
            end

            // Datapath register is valid once the count expires,
            // so it is sampled on the following edge
            done <= (cnt == 3'd1);
            if (done) begin
                result_q <= result;
            end

            // Writes to read-only or unmapped addresses fall through
            if (accept && wb_we) begin
                case (wb_adr)
                    fpu_pkg::REG_OPA: op_a <= wb_dat_i[fpu_pkg::FP_W-1:0];
                    fpu_pkg::REG_OPB: op_b <= wb_dat_i[fpu_pkg::FP_W-1:0];
                    fpu_pkg::REG_CMD: opcode <= cmd_op;
                    default: ;
                endcase
            end
        end
    end

    // Read mux, sampled by the host while ack is high
    always_comb begin
        wb_dat_o = '0;
        case (wb_adr)
            fpu_pkg::REG_OPA:    wb_dat_o[fpu_pkg::FP_W-1:0] = op_a;
            fpu_pkg::REG_OPB:    wb_dat_o[fpu_pkg::FP_W-1:0] = op_b;
            fpu_pkg::REG_CMD:    wb_dat_o[2:0] = opcode;
            fpu_pkg::REG_RESULT: wb_dat_o[fpu_pkg::FP_W-1:0] = result_q;
            fpu_pkg::REG_STATUS: wb_dat_o[0] = busy;
            default:             wb_dat_o = '0;
        endcase
    end

endmodule

//--- verilog/fpu_wb_top.sv
`timescale 1ns/1ps

module fpu_wb_top (
    input  logic                      iCLK,
    input  logic                      rst,
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    input  logic [fpu_pkg::ADR_W-1:0] wb_adr,
    input  logic [fpu_pkg::BUS_W-1:0] wb_dat_i,
    output logic [fpu_pkg::BUS_W-1:0] wb_dat_o,
    output logic                      wb_ack
);

    // Slave to datapath
    fpu_pkg::fp_t     op_a;
    fpu_pkg::fp_t     op_b;
    fpu_pkg::fpu_op_e opcode;
    fpu_pkg::fp_t     result;

    fpu_wb_slave u_slave (
        .iCLK     (iCLK),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack   (wb_ack),
        .op_a     (op_a),
        .op_b     (op_b),
        .opcode   (opcode),
        .result   (result)
    );

    fpu_datapath u_datapath (
        .iCLK   (iCLK),
        .rst    (rst),
        .opcode (opcode),
        .op_a   (op_a),
        .op_b   (op_b),
        .result (result)
    );

endmodule

//--- sim/tb_fpu.sv
`timescale 1ns/1ps

module tb_fpu;

    logic                      iCLK;
    logic                      rst;
    logic                      wb_cyc;
    logic                      wb_stb;
    logic                      wb_we;
    logic [fpu_pkg::ADR_W-1:0] wb_adr;
    logic [fpu_pkg::BUS_W-1:0] wb_dat_i;
    logic [fpu_pkg::BUS_W-1:0] wb_dat_o;
    logic                      wb_ack;

    // Run bookkeeping
    int          errors;
    int          checks;
    int          tests;
    int          cycle;
    int          ack_cycle;
    logic [31:0] lcg_state;

    fpu_wb_top u_dut (
        .iCLK     (iCLK),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack   (wb_ack)
    );

    // 4 ns clock
    initial begin
        iCLK = 1'b0;
        forever #2 iCLK = ~iCLK;
    end

    // Free-running edge count for ack timing
    always @(posedge iCLK) begin
        cycle <= cycle + 1;
    end

    // Numerical Recipes LCG step
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // 2^k as a float word: sign 0, fraction 0
    function automatic logic [31:0] pow2(input int k);
        return {5'b0, 1'b0, 8'(127 + k), 18'd0};
    endfunction

    // Low 16 bits as a signed integer
    function automatic int low16(input logic [31:0] w);
        return int'($signed(w[15:0]));
    endfunction

    // Decode a float word into a real, zero exponent means zero
    function automatic real fp_to_real(input logic [26:0] w);
        real m;
        int  e;
        if (w[25:18] == 8'd0) begin
            return 0.0;
        end
        m = 1.0 + real'(w[17:0]) / 262144.0;
        e = int'(w[25:18]) - 127;
        for (int i = 0; i < e; i++) begin
            m = m * 2.0;
        end
        for (int i = 0; i > e; i--) begin
            m = m / 2.0;
        end
        return w[26] ? -m : m;
    endfunction

    // Classic write, strobe held until ack
    task automatic wb_write(input logic [fpu_pkg::ADR_W-1:0] adr, input logic [31:0] data);
        int waited;
        waited = 0;
        @(negedge iCLK);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_i = data;
        do begin
            @(negedge iCLK);
            waited++;
        end while (!wb_ack && waited < 64);
        if (!wb_ack) begin
            $display("write to address %0d got no ack within %0d cycles", adr, waited);
            errors++;
        end
        ack_cycle = cycle;
        // Bus idle for at least one edge before the next access
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    // Classic read, data taken on the ack cycle
    task automatic wb_read(input logic [fpu_pkg::ADR_W-1:0] adr, output logic [31:0] data);
        int waited;
        waited = 0;
        @(negedge iCLK);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        do begin
            @(negedge iCLK);
            waited++;
        end while (!wb_ack && waited < 64);
        if (!wb_ack) begin
            $display("read of address %0d got no ack within %0d cycles", adr, waited);
            errors++;
        end
        data      = wb_dat_o;
        ack_cycle = cycle;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
    endtask

    // Load operands, launch, read back the result
    task automatic run_op(input fpu_pkg::fpu_op_e op, input logic [31:0] a,
                          input logic [31:0] b, output logic [31:0] res);
        wb_write(fpu_pkg::REG_OPA, a);
        wb_write(fpu_pkg::REG_OPB, b);
        wb_write(fpu_pkg::REG_CMD, {29'b0, op});
        wb_read(fpu_pkg::REG_RESULT, res);
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        checks++;
        assert (got == exp) else begin
            $display("mismatch at %0d ns: %s, got %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // Relative error within 1 %
    task automatic check_close(input real got, input real exp, input string what);
        checks++;
        assert ((got - exp) <= 0.01 * exp && (exp - got) <= 0.01 * exp) else begin
            $display("mismatch at %0d ns: %s, got %f, expected %f", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("%s", what);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int start);
        tests++;
        if (errors == start) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - start);
        end
    endtask

    task automatic test_round_trip();
        int          vals [22];
        int          start;
        logic [31:0] fpw;
        logic [31:0] back;
        start   = errors;
        vals[0] = 0;
        vals[1] = -1;
        // Random integers in -32767..32767
        for (int i = 2; i < 22; i++) begin
            lcg_state = lcg_next(lcg_state);
            vals[i]   = int'({1'b0, lcg_state[31:16]} % 17'd65535) - 32767;
        end
        for (int i = 0; i < 22; i++) begin
            run_op(fpu_pkg::OP_INT_TO_FP, 32'(vals[i]), 32'd0, fpw);
            run_op(fpu_pkg::OP_FP_TO_INT, fpw, 32'd0, back);
            check_value(32'(low16(back)), 32'(vals[i]),
                        $sformatf("round trip of %0d", vals[i]));
        end
        finish_test("round trip", start);
    endtask

    task automatic test_clipping();
        int          start;
        logic [31:0] res;
        start = errors;
        // Exponent 150 is far above bias plus 14
        run_op(fpu_pkg::OP_FP_TO_INT, {5'b0, 1'b0, 8'd150, 18'd0}, 32'd0, res);
        check_value(32'(low16(res)), 32'd32767, "positive clip");
        run_op(fpu_pkg::OP_FP_TO_INT, {5'b0, 1'b1, 8'd150, 18'd0}, 32'd0, res);
        check_value(32'(low16(res)), 32'(-32767), "negative clip");
        // Just under one
        run_op(fpu_pkg::OP_FP_TO_INT, {5'b0, 1'b0, 8'd126, 18'h3ffff}, 32'd0, res);
        check_value(32'(low16(res)), 32'd0, "magnitude below one");
        finish_test("clipping", start);
    endtask

    task automatic test_exact_arith();
        int          start;
        logic [31:0] res;
        logic [31:0] three;
        start = errors;
        three = {5'b0, 1'b0, 8'd128, 18'h20000};
        run_op(fpu_pkg::OP_ADD, pow2(0), pow2(0), res);
        check_value(res, pow2(1), "1.0 + 1.0");
        run_op(fpu_pkg::OP_ADD, pow2(3), 32'd0, res);
        check_value(res, pow2(3), "8.0 + 0");
        // Subtraction by flipping the sign of B
        run_op(fpu_pkg::OP_ADD, three, three | 32'h0400_0000, res);
        check_value(res, 32'd0, "3.0 + -3.0");
        run_op(fpu_pkg::OP_MUL, pow2(2), pow2(-5), res);
        check_value(res, pow2(-3), "2^2 * 2^-5");
        run_op(fpu_pkg::OP_MUL, pow2(4), pow2(3), res);
        check_value(res, pow2(7), "2^4 * 2^3");
        run_op(fpu_pkg::OP_MUL, pow2(5), 32'd0, res);
        check_value(res, 32'd0, "2^5 * 0");
        finish_test("exact arith", start);
    endtask

    task automatic test_inv_sqrt();
        int          start;
        logic [31:0] res;
        start = errors;
        run_op(fpu_pkg::OP_INV_SQRT, pow2(2), 32'd0, res);
        check_close(fp_to_real(res[26:0]), 0.5, "1/sqrt(4.0)");
        run_op(fpu_pkg::OP_INV_SQRT, pow2(4), 32'd0, res);
        check_close(fp_to_real(res[26:0]), 0.25, "1/sqrt(16.0)");
        run_op(fpu_pkg::OP_INV_SQRT, pow2(-2), 32'd0, res);
        check_close(fp_to_real(res[26:0]), 2.0, "1/sqrt(0.25)");
        finish_test("inv sqrt", start);
    endtask

    task automatic test_back_pressure();
        int          start;
        int          launch;
        int          lat;
        logic [31:0] data;
        start = errors;
        // Inverse square root result is ready six cycles after launch
        lat   = 6;
        wb_write(fpu_pkg::REG_OPA, pow2(2));
        wb_write(fpu_pkg::REG_OPB, pow2(1));
        wb_write(fpu_pkg::REG_CMD, {29'b0, fpu_pkg::OP_INV_SQRT});
        launch = ack_cycle;
        wb_read(fpu_pkg::REG_STATUS, data);
        check_value(data, 32'd1, "status right after launch");
        // Result read stalls until busy falls
        wb_read(fpu_pkg::REG_RESULT, data);
        check_true(ack_cycle - launch >= lat,
                   $sformatf("result read acked %0d cycles after launch, before the result",
                             ack_cycle - launch));
        check_close(fp_to_real(data[26:0]), 0.5, "stalled 1/sqrt(4.0)");
        // Command during busy waits for idle, then multiplies 4.0 by 2.0
        wb_write(fpu_pkg::REG_CMD, {29'b0, fpu_pkg::OP_INV_SQRT});
        launch = ack_cycle;
        wb_write(fpu_pkg::REG_CMD, {29'b0, fpu_pkg::OP_MUL});
        check_true(ack_cycle - launch >= lat,
                   $sformatf("command write during busy acked after only %0d cycles",
                             ack_cycle - launch));
        wb_read(fpu_pkg::REG_RESULT, data);
        check_value(data, pow2(3), "multiply launched during busy");
        finish_test("back pressure", start);
    endtask

    initial begin
        rst       = 1'b1;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_i  = '0;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        ack_cycle = 0;
        lcg_state = 32'h049f_a070;
        repeat (16) @(posedge iCLK);
        @(negedge iCLK);
        rst = 1'b0;

        test_round_trip();
        test_clipping();
        test_exact_arith();
        test_inv_sqrt();
        test_back_pressure();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- build.f
verilog/fpu_pkg.sv
verilog/fp_mul.sv
verilog/fp_add.sv
verilog/fp_inv_sqrt.sv
verilog/fp_int_convert.sv
verilog/fpu_datapath.sv
verilog/fpu_wb_slave.sv
verilog/fpu_wb_top.sv
sim/tb_fpu.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the FPU testbench with Verilator, run it, judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert -Wno-fatal --top-module tb_fpu -f build.f -o sim_fpu \
    && ./obj_dir/sim_fpu | tee sim.log \
    || { echo "build or simulation did not run"; exit 1; }

# A missing log or a reported failure both fail the run
test -s sim.log || { echo "no simulation log"; exit 1; }
grep -q ">>> FAIL" sim.log && { echo "simulation reported failure"; exit 1; } || exit 0
